// File: common/flow_pkg.sv
/* Descriptor layouts for immediate writes to legacy I2C targets only.
   Bit positions follow the HCI command, response and DAT formats. */
package flow_pkg;

  typedef logic [63:0] cmd_desc_t;
  typedef logic [31:0] resp_desc_t;
  typedef logic [63:0] dat_entry_t;
  typedef logic [7:0]  fmt_byte_t;
  typedef logic [3:0]  tid_t;
  typedef logic [2:0]  dtt_t;
  typedef logic [4:0]  dev_index_t;
  typedef logic [6:0]  i2c_addr_t;

  typedef enum logic [2:0] {
    RegularTransfer       = 3'd0,
    ImmediateDataTransfer = 3'd1,
    AddressAssignment     = 3'd2,
    ComboTransfer         = 3'd3,
    InternalControl       = 3'd7
  } cmd_attr_e;

  typedef enum logic [3:0] {
    Success      = 4'h0,
    NotSupported = 4'hC
  } resp_err_e;

  typedef enum logic [2:0] {
    Idle        = 3'd0,
    WaitForCmd  = 3'd1,
    FetchDat    = 3'd2,
    I2cWriteImm = 3'd3,
    WriteResp   = 3'd4
  } flow_state_e;

  // Command descriptor fields
  localparam int unsigned CmdAttrLsb   = 0;
  localparam int unsigned CmdAttrMsb   = 2;
  localparam int unsigned CmdTidLsb    = 3;
  localparam int unsigned CmdTidMsb    = 6;
  localparam int unsigned CmdDevIdxLsb = 16;
  localparam int unsigned CmdDevIdxMsb = 20;
  localparam int unsigned CmdDttLsb    = 23;
  localparam int unsigned CmdDttMsb    = 25;
  localparam int unsigned CmdTocBit    = 31;
  localparam int unsigned CmdDataLsb   = 32;
  localparam int unsigned CmdDataMsb   = 63;

  // Response descriptor fields
  localparam int unsigned RespLenLsb    = 0;
  localparam int unsigned RespLenMsb    = 15;
  localparam int unsigned RespTidLsb    = 24;
  localparam int unsigned RespTidMsb    = 27;
  localparam int unsigned RespStatusLsb = 28;
  localparam int unsigned RespStatusMsb = 31;

  // DAT entry fields
  localparam int unsigned DatAddrLsb   = 0;
  localparam int unsigned DatAddrMsb   = 6;
  localparam int unsigned DatLegacyBit = 31;

  // DTT values from here up carry a defining byte in data byte 1
  localparam dtt_t DttDefByteMin = 3'd5;

endpackage

// File: src/cmd_fetch.sv
/* Fields stay valid from the cycle after accept until the next accept.
   Attribute codes outside cmd_attr_e pass through the cast unchanged. */
module cmd_fetch
  import flow_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fetch_en_i,
  input  logic        cmd_queue_rvalid_i,
  output logic        cmd_queue_rready_o,
  input  cmd_desc_t   cmd_queue_rdata_i,
  output logic        cmd_taken_o,
  output cmd_attr_e   attr_o,
  output tid_t        tid_o,
  output dev_index_t  dev_index_o,
  output dtt_t        dtt_o,
  output logic        toc_o,
  output logic [31:0] data_bytes_o
);

  cmd_desc_t desc_q;

  // Ready follows the FSM request directly
  assign cmd_queue_rready_o = fetch_en_i;
  assign cmd_taken_o        = cmd_queue_rvalid_i && cmd_queue_rready_o;

  always_ff @(posedge clk_i) begin
    if (cmd_taken_o) begin
      desc_q <= cmd_queue_rdata_i;
    end
  end

  // Field decode of the held descriptor
  assign attr_o       = cmd_attr_e'(desc_q[CmdAttrMsb:CmdAttrLsb]);
  assign tid_o        = desc_q[CmdTidMsb:CmdTidLsb];
  assign dev_index_o  = desc_q[CmdDevIdxMsb:CmdDevIdxLsb];
  assign dtt_o        = desc_q[CmdDttMsb:CmdDttLsb];
  assign toc_o        = desc_q[CmdTocBit];
  assign data_bytes_o = desc_q[CmdDataMsb:CmdDataLsb];

  // Fetch drops right after an accept so each command takes one descriptor
  a_single_accept: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cmd_taken_o |=> !fetch_en_i
  );

endmodule

// File: src/dat_reader.sv
/* Assumes the DAT returns data exactly one cycle after the read strobe.
   dat_done follows dat_start by a fixed 3 cycles. */
module dat_reader
  import flow_pkg::*;
#(
  parameter int unsigned DatDepth = 32
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        dat_start_i,
  input  dev_index_t                  dev_index_i,
  output logic                        dat_read_valid_o,
  output logic [$clog2(DatDepth)-1:0] dat_index_o,
  input  dat_entry_t                  dat_rdata_i,
  output logic                        dat_done_o,
  output i2c_addr_t                   static_addr_o,
  output logic                        legacy_i2c_o
);

  localparam int unsigned IdxW = $clog2(DatDepth);

  logic read_q;
  logic capture_q;
  logic done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_q    <= 1'b0;
      capture_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      read_q    <= dat_start_i;
      capture_q <= read_q;
      done_q    <= capture_q;
    end
  end

  // Entry is on the bus in the cycle after the strobe
  always_ff @(posedge clk_i) begin
    if (capture_q) begin
      static_addr_o <= dat_rdata_i[DatAddrMsb:DatAddrLsb];
      legacy_i2c_o  <= dat_rdata_i[DatLegacyBit];
    end
  end

  assign dat_read_valid_o = read_q;
  assign dat_index_o      = IdxW'(dev_index_i);
  assign dat_done_o       = done_q;

  a_read_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dat_read_valid_o |=> !dat_read_valid_o
  );

endmodule

// File: src/imm_byte_seq.sv
/* Sends the address byte then up to four data bytes; a defining byte is never sent.
   DTT 0 and 5 send the address alone. Inputs must hold while the sequence runs. */
module imm_byte_seq
  import flow_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        seq_start_i,
  input  i2c_addr_t   static_addr_i,
  input  dtt_t        dtt_i,
  input  logic        toc_i,
  input  logic [31:0] data_bytes_i,
  output logic        fmt_valid_o,
  input  logic        fmt_ready_i,
  output fmt_byte_t   fmt_byte_o,
  output logic        fmt_start_o,
  output logic        fmt_stop_o,
  output logic        seq_done_o
);

  logic       busy_q;
  logic       done_q;
  logic [2:0] cnt_q;
  logic       use_def;
  dtt_t       last_idx;
  logic       last_entry;
  logic       fmt_fire;
  logic [1:0] byte_sel;
  fmt_byte_t  data_byte;

  assign use_def    = dtt_i >= DttDefByteMin;
  assign last_idx   = use_def ? dtt_i - DttDefByteMin : dtt_i;
  assign last_entry = cnt_q == last_idx;
  assign fmt_fire   = busy_q && fmt_ready_i;

  // Entry k carries data byte k, or k+1 when byte 1 is the defining byte
  assign byte_sel = 2'(cnt_q + {2'b00, use_def} - 3'd1);

  always_comb begin
    unique case (byte_sel)
      2'd0: data_byte = data_bytes_i[7:0];
      2'd1: data_byte = data_bytes_i[15:8];
      2'd2: data_byte = data_bytes_i[23:16];
      default: data_byte = data_bytes_i[31:24];
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= fmt_fire && last_entry;
      if (seq_start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (fmt_fire) begin
        if (last_entry) begin
          busy_q <= 1'b0;
        end else begin
          cnt_q <= cnt_q + 3'd1;
        end
      end
    end
  end

  // Entry 0 is the address with the write bit clear
  assign fmt_byte_o  = (cnt_q == '0) ? {static_addr_i, 1'b0} : data_byte;
  assign fmt_start_o = cnt_q == '0;
  assign fmt_stop_o  = toc_i && last_entry;
  assign fmt_valid_o = busy_q;
  assign seq_done_o  = done_q;

  a_fmt_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    fmt_valid_o && !fmt_ready_i |=> fmt_valid_o && $stable(fmt_byte_o)
      && $stable(fmt_start_o) && $stable(fmt_stop_o)
  );

endmodule

// File: src/flow_ctrl_fsm.sv
/* One command in flight at a time; the response length is always zero.
   Only immediate commands to legacy I2C entries are executed. */
module flow_ctrl_fsm
  import flow_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       fsm_en_i,
  output logic       fsm_idle_o,
  output logic       fetch_en_o,
  input  logic       cmd_taken_i,
  input  cmd_attr_e  attr_i,
  input  tid_t       tid_i,
  output logic       dat_start_o,
  input  logic       dat_done_i,
  input  logic       legacy_i2c_i,
  output logic       seq_start_o,
  input  logic       seq_done_i,
  output logic       resp_wvalid_o,
  input  logic       resp_wready_i,
  output resp_desc_t resp_wdata_o
);

  flow_state_e state_q, state_d;
  logic        dat_start_q, dat_start_d;
  logic        seq_start_q, seq_start_d;
  logic        resp_valid_q;
  logic        resp_load;
  resp_err_e   resp_status_d;
  resp_desc_t  resp_data_q, resp_next;

  always_comb begin
    state_d       = state_q;
    dat_start_d   = 1'b0;
    seq_start_d   = 1'b0;
    resp_load     = 1'b0;
    resp_status_d = Success;
    unique case (state_q)
      Idle: begin
        if (fsm_en_i) state_d = WaitForCmd;
      end
      WaitForCmd: begin
        if (cmd_taken_i) begin
          state_d     = FetchDat;
          dat_start_d = 1'b1;
        end
      end
      FetchDat: begin
        if (dat_done_i) begin
          if (attr_i == ImmediateDataTransfer && legacy_i2c_i) begin
            state_d     = I2cWriteImm;
            seq_start_d = 1'b1;
          end else begin
            // Non-immediate command, or an I3C target
            state_d       = WriteResp;
            resp_load     = 1'b1;
            resp_status_d = NotSupported;
          end
        end
      end
      I2cWriteImm: begin
        if (seq_done_i) begin
          state_d   = WriteResp;
          resp_load = 1'b1;
        end
      end
      WriteResp: begin
        if (resp_wready_i) state_d = Idle;
      end
      default: state_d = Idle;
    endcase
  end

  // Response word built from the held TID
  always_comb begin
    resp_next = '0;
    resp_next[RespStatusMsb:RespStatusLsb] = resp_status_d;
    resp_next[RespTidMsb:RespTidLsb]       = tid_i;
    resp_next[RespLenMsb:RespLenLsb]       = '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Idle;
      dat_start_q  <= 1'b0;
      seq_start_q  <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      dat_start_q <= dat_start_d;
      seq_start_q <= seq_start_d;
      if (resp_load) begin
        resp_valid_q <= 1'b1;
      end else if (resp_valid_q && resp_wready_i) begin
        resp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp_load) resp_data_q <= resp_next;
  end

  assign fsm_idle_o    = state_q == Idle;
  assign fetch_en_o    = state_q == WaitForCmd;
  assign dat_start_o   = dat_start_q;
  assign seq_start_o   = seq_start_q;
  assign resp_wvalid_o = resp_valid_q;
  assign resp_wdata_o  = resp_data_q;

  a_resp_in_state: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    resp_wvalid_o |-> state_q == WriteResp
  );

endmodule

// File: src/flow_active.sv
/* Executes immediate writes to legacy I2C targets; every other command gets NotSupported.
   DAT index width is $clog2(DatDepth), the device index is truncated to fit. */
module flow_active
  import flow_pkg::*;
#(
  parameter int unsigned DatDepth = 32
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        fsm_en_i,
  output logic                        fsm_idle_o,
  input  logic                        cmd_queue_rvalid_i,
  output logic                        cmd_queue_rready_o,
  input  cmd_desc_t                   cmd_queue_rdata_i,
  output logic                        dat_read_valid_o,
  output logic [$clog2(DatDepth)-1:0] dat_index_o,
  input  dat_entry_t                  dat_rdata_i,
  output logic                        fmt_valid_o,
  input  logic                        fmt_ready_i,
  output fmt_byte_t                   fmt_byte_o,
  output logic                        fmt_start_o,
  output logic                        fmt_stop_o,
  output logic                        resp_wvalid_o,
  input  logic                        resp_wready_i,
  output resp_desc_t                  resp_wdata_o
);

  logic        fetch_en;
  logic        cmd_taken;
  cmd_attr_e   attr;
  tid_t        tid;
  dev_index_t  dev_index;
  dtt_t        dtt;
  logic        toc;
  logic [31:0] data_bytes;

  logic        dat_start;
  logic        dat_done;
  i2c_addr_t   static_addr;
  logic        legacy_i2c;

  logic        seq_start;
  logic        seq_done;

  cmd_fetch u_cmd_fetch (
    .clk_i,
    .rst_ni,
    .fetch_en_i         (fetch_en),
    .cmd_queue_rvalid_i,
    .cmd_queue_rready_o,
    .cmd_queue_rdata_i,
    .cmd_taken_o        (cmd_taken),
    .attr_o             (attr),
    .tid_o              (tid),
    .dev_index_o        (dev_index),
    .dtt_o              (dtt),
    .toc_o              (toc),
    .data_bytes_o       (data_bytes)
  );

  dat_reader #(
    .DatDepth(DatDepth)
  ) u_dat_reader (
    .clk_i,
    .rst_ni,
    .dat_start_i     (dat_start),
    .dev_index_i     (dev_index),
    .dat_read_valid_o,
    .dat_index_o,
    .dat_rdata_i,
    .dat_done_o      (dat_done),
    .static_addr_o   (static_addr),
    .legacy_i2c_o    (legacy_i2c)
  );

  imm_byte_seq u_imm_byte_seq (
    .clk_i,
    .rst_ni,
    .seq_start_i  (seq_start),
    .static_addr_i(static_addr),
    .dtt_i        (dtt),
    .toc_i        (toc),
    .data_bytes_i (data_bytes),
    .fmt_valid_o,
    .fmt_ready_i,
    .fmt_byte_o,
    .fmt_start_o,
    .fmt_stop_o,
    .seq_done_o   (seq_done)
  );

  flow_ctrl_fsm u_flow_ctrl_fsm (
    .clk_i,
    .rst_ni,
    .fsm_en_i,
    .fsm_idle_o,
    .fetch_en_o   (fetch_en),
    .cmd_taken_i  (cmd_taken),
    .attr_i       (attr),
    .tid_i        (tid),
    .dat_start_o  (dat_start),
    .dat_done_i   (dat_done),
    .legacy_i2c_i (legacy_i2c),
    .seq_start_o  (seq_start),
    .seq_done_i   (seq_done),
    .resp_wvalid_o,
    .resp_wready_i,
    .resp_wdata_o
  );

endmodule

// File: bench/tb_clock_gen.sv
/* 10 ns clock; reset stays low for ResetCycles rising edges, then releases on an edge. */
module tb_clock_gen #(
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: bench/flow_checker.sv
/* Samples handshakes at the rising edge; expected values come from the testbench top.
   Up to five format entries per test, packed as {stop, start, byte} in 12 bits each. */
module flow_checker
  import flow_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fsm_en_i,
  input  logic        fsm_idle_i,
  input  logic        cmd_rready_i,
  input  logic        dat_read_valid_i,
  input  dev_index_t  dat_index_i,
  input  logic        fmt_valid_i,
  input  logic        fmt_ready_i,
  input  fmt_byte_t   fmt_byte_i,
  input  logic        fmt_start_i,
  input  logic        fmt_stop_i,
  input  logic        resp_wvalid_i,
  input  logic        resp_wready_i,
  input  resp_desc_t  resp_wdata_i,
  input  int unsigned test_num_i,
  input  logic [7:0]  exp_cnt_i,
  input  logic [59:0] exp_fmt_i,
  input  resp_desc_t  exp_resp_i,
  input  dev_index_t  exp_dat_index_i,
  output int unsigned tests_done_o,
  output int unsigned errors_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned entry_idx = 0;
  int unsigned dat_reads = 0;
  int unsigned test_errs = 0;
  int unsigned err_total = 0;
  int unsigned done_total = 0;
  bit          en_seen = 1'b0;
  logic [11:0] exp_entry;

  initial begin
    tests_done_o = 0;
    errors_o     = 0;
  end

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR test %0d: %s got 0x%0h expected 0x%0h", test_num_i, name, got, exp);
      test_errs++;
    end
  endtask

  task automatic note_failure(input string what);
    $display("test %0d: %s", test_num_i, what);
    test_errs++;
  endtask

  task automatic finish_test();
    $display("test %0d done, %0d errors", test_num_i, test_errs);
    err_total += test_errs;
    done_total++;
    test_errs = 0;
    entry_idx = 0;
    dat_reads = 0;
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      // Idle check lasts until the controller is first enabled
      if (!en_seen) begin
        compare_value("fsm_idle_o", fsm_idle_i, 1);
        compare_value("cmd_queue_rready_o", cmd_rready_i, 0);
        compare_value("dat_read_valid_o", dat_read_valid_i, 0);
        compare_value("fmt_valid_o", fmt_valid_i, 0);
        compare_value("resp_wvalid_o", resp_wvalid_i, 0);
        if (fsm_en_i) begin
          en_seen = 1'b1;
          finish_test();
        end
      end
      if (dat_read_valid_i) begin
        compare_value("dat_index_o", dat_index_i, exp_dat_index_i);
        dat_reads++;
      end
      if (fmt_valid_i && fmt_ready_i) begin
        if (entry_idx >= exp_cnt_i) begin
          note_failure("format entry sent beyond the expected list");
        end else begin
          exp_entry = exp_fmt_i[entry_idx*12 +: 12];
          compare_value("fmt_byte_o", fmt_byte_i, exp_entry[7:0]);
          compare_value("fmt_start_o", fmt_start_i, exp_entry[8]);
          compare_value("fmt_stop_o", fmt_stop_i, exp_entry[9]);
        end
        entry_idx++;
      end
      if (resp_wvalid_i && resp_wready_i) begin
        if (entry_idx != exp_cnt_i) begin
          note_failure($sformatf("saw %0d format entries where %0d were expected",
                                 entry_idx, exp_cnt_i));
        end
        if (dat_reads != 1) begin
          note_failure($sformatf("saw %0d DAT reads where one was expected", dat_reads));
        end
        compare_value("resp_wdata_o", resp_wdata_i, exp_resp_i);
        finish_test();
      end
    end
    tests_done_o <= done_total;
    errors_o     <= err_total;
  end

endmodule

// File: bench/tb_flow_active.sv
/* Runs the tests in bench/flow_stimulus.txt, nine hex words per test.
   The DAT model answers one cycle after the read strobe. */
module tb_flow_active
  import flow_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumTests      = 12;
  localparam int unsigned FieldsPerTest = 9;
  localparam int unsigned WaitLimit     = 200;
  localparam int unsigned IdleCycles    = 10;
  localparam int unsigned RandSeed      = 94877;
  localparam int unsigned DatDepth      = 32;

  logic clk, rst_n;
  logic fsm_en, fsm_idle;
  logic cmd_rvalid, cmd_rready;
  cmd_desc_t cmd_rdata;
  logic dat_read_valid;
  logic [$clog2(DatDepth)-1:0] dat_index;
  dat_entry_t dat_rdata;
  logic fmt_valid, fmt_ready, fmt_start, fmt_stop;
  fmt_byte_t fmt_byte;
  logic resp_wvalid, resp_wready;
  resp_desc_t resp_wdata;

  int unsigned test_num;
  logic [7:0]  exp_cnt;
  logic [59:0] exp_fmt;
  resp_desc_t  exp_resp;
  dev_index_t  exp_dat_idx;
  int unsigned tests_done, errors;
  bit          run_ok;

  logic [63:0] stim_mem [0:NumTests*FieldsPerTest-1];
  dat_entry_t  dat_table [0:DatDepth-1];

  tb_clock_gen #(.ResetCycles(8)) clk_gen0 (.clk_o(clk), .rst_no(rst_n));

  flow_active #(.DatDepth(DatDepth)) dut0 (
    .clk_i(clk), .rst_ni(rst_n), .fsm_en_i(fsm_en), .fsm_idle_o(fsm_idle),
    .cmd_queue_rvalid_i(cmd_rvalid), .cmd_queue_rready_o(cmd_rready),
    .cmd_queue_rdata_i(cmd_rdata), .dat_read_valid_o(dat_read_valid),
    .dat_index_o(dat_index), .dat_rdata_i(dat_rdata), .fmt_valid_o(fmt_valid),
    .fmt_ready_i(fmt_ready), .fmt_byte_o(fmt_byte), .fmt_start_o(fmt_start),
    .fmt_stop_o(fmt_stop), .resp_wvalid_o(resp_wvalid), .resp_wready_i(resp_wready),
    .resp_wdata_o(resp_wdata)
  );

  flow_checker chk0 (
    .clk_i(clk), .rst_ni(rst_n), .fsm_en_i(fsm_en), .fsm_idle_i(fsm_idle),
    .cmd_rready_i(cmd_rready), .dat_read_valid_i(dat_read_valid),
    .dat_index_i(dat_index), .fmt_valid_i(fmt_valid), .fmt_ready_i(fmt_ready),
    .fmt_byte_i(fmt_byte), .fmt_start_i(fmt_start), .fmt_stop_i(fmt_stop),
    .resp_wvalid_i(resp_wvalid), .resp_wready_i(resp_wready), .resp_wdata_i(resp_wdata),
    .test_num_i(test_num), .exp_cnt_i(exp_cnt), .exp_fmt_i(exp_fmt),
    .exp_resp_i(exp_resp), .exp_dat_index_i(exp_dat_idx),
    .tests_done_o(tests_done), .errors_o(errors)
  );

  // DAT model with one cycle of read latency
  always @(posedge clk) begin
    if (dat_read_valid) dat_rdata <= dat_table[dat_index];
  end

  // Random back-pressure on both output paths
  always @(posedge clk) begin
    fmt_ready   <= ($urandom % 3) != 0;
    resp_wready <= ($urandom % 2) != 0;
  end

  task automatic wait_cmd_accept(output bit ok);
    int unsigned cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < WaitLimit) begin
      @(posedge clk);
      ok = cmd_rready;
      cycles++;
    end
  endtask

  task automatic wait_tests_done(input int unsigned target, output bit ok);
    int unsigned cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < WaitLimit) begin
      @(posedge clk);
      ok = tests_done >= target;
      cycles++;
    end
  endtask

  task automatic run_test(input int unsigned t);
    int unsigned base;
    cmd_desc_t   desc;
    bit          ok;
    base = t * FieldsPerTest;
    desc = stim_mem[base];
    dat_table[desc[CmdDevIdxMsb:CmdDevIdxLsb]] = stim_mem[base+1];
    test_num    <= t + 1;
    exp_cnt     <= stim_mem[base+2][7:0];
    exp_fmt     <= {stim_mem[base+7][11:0], stim_mem[base+6][11:0], stim_mem[base+5][11:0],
                    stim_mem[base+4][11:0], stim_mem[base+3][11:0]};
    exp_resp    <= stim_mem[base+8][31:0];
    exp_dat_idx <= desc[CmdDevIdxMsb:CmdDevIdxLsb];
    cmd_rdata   <= desc;
    cmd_rvalid  <= 1'b1;
    wait_cmd_accept(ok);
    cmd_rvalid <= 1'b0;
    if (!ok) begin
      $display("test %0d: command was not accepted in time", t + 1);
      run_ok = 1'b0;
    end else begin
      wait_tests_done(t + 2, ok);
      if (!ok) begin
        $display("test %0d: no response arrived in time", t + 1);
        run_ok = 1'b0;
      end
    end
  endtask

  initial begin
    int unsigned seed_val;
    int unsigned cycles;
    bit          ok;
    seed_val    = RandSeed;
    seed_val    = $urandom(seed_val);
    run_ok      = 1'b1;
    fsm_en      = 1'b0;
    cmd_rvalid  = 1'b0;
    cmd_rdata   = '0;
    dat_rdata   = '0;
    fmt_ready   = 1'b0;
    resp_wready = 1'b0;
    test_num    = 0;
    exp_cnt     = '0;
    exp_fmt     = '0;
    exp_resp    = '0;
    exp_dat_idx = '0;
    for (int i = 0; i < DatDepth; i++) begin
      dat_table[i] = {32'(i) ^ 32'h5a5a_0000, 32'(i) * 32'h0101_0101};
    end
    $readmemh("bench/flow_stimulus.txt", stim_mem);
    if ($isunknown(stim_mem[0])) begin
      $display("stimulus file bench/flow_stimulus.txt could not be read");
      run_ok = 1'b0;
    end
    cycles = 0;
    while (!rst_n && cycles < WaitLimit) begin
      @(posedge clk);
      cycles++;
    end
    if (!rst_n) begin
      $display("reset was never released");
      run_ok = 1'b0;
    end
    // A descriptor is offered while the controller is still disabled
    cmd_rdata  <= 64'h0123_4567_8082_0019;
    cmd_rvalid <= 1'b1;
    repeat (IdleCycles) @(posedge clk);
    cmd_rvalid <= 1'b0;
    fsm_en     <= 1'b1;
    wait_tests_done(1, ok);
    if (!ok) begin
      $display("idle check did not complete in time");
      run_ok = 1'b0;
    end
    for (int t = 0; t < NumTests; t++) begin
      if (run_ok) run_test(t);
    end
    @(posedge clk);
    $display("tests done: %0d, errors: %0d", tests_done, errors);
    if (run_ok && errors == 0 && tests_done == NumTests + 1) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: bench/flow_stimulus.txt
// descriptor  dat_entry  entry_count  entry0 entry1 entry2 entry3 entry4  response
// Entry is {stop, start, byte}: 1xx start only, 2xx stop only, 3xx both, 0xx neither
44332211_80820019 00000000_80000050 2 1a0 211 000 000 000 03000000
d4c3b2a1_01070029 00000000_8000002c 3 158 0a1 0b2 000 000 05000000
04030201_819f0051 00000000_8000007f 4 1fe 001 002 203 000 0a000000
efbeadde_82000079 00000000_80000008 5 110 0de 0ad 0be 2ef 0f000000
c33ca55a_02090009 00000000_80000033 5 166 05a 0a5 03c 0c3 01000000
998877db_82840031 00000000_80000021 1 342 000 000 000 000 06000000
563412ee_83100039 00000000_8000001a 2 134 212 000 000 000 07000000
efcdabff_03830041 00000000_80000045 3 18a 0ab 0cd 000 000 08000000
44332211_81050058 00000000_80000010 0 000 000 000 000 000 cb000000
0a0b0c0d_81860061 00000000_00000022 0 000 000 000 000 000 cc000000
55667788_00810013 00000000_80000077 0 000 000 000 000 000 c2000000
0000bc9a_810b0071 00000000_8000005d 3 1ba 09a 2bc 000 000 0e000000

// File: flow_active.f
common/flow_pkg.sv
src/cmd_fetch.sv
src/dat_reader.sv
src/imm_byte_seq.sv
src/flow_ctrl_fsm.sv
src/flow_active.sv
bench/tb_clock_gen.sv
bench/flow_checker.sv
bench/tb_flow_active.sv
